/* build.f */
logic/l2_smi_pkg.sv
logic/l2_smi_if.sv
logic/l2_request_fifo.sv
logic/l2_pending_miss.sv
logic/l2_miss_queues.sv
logic/l2_line_burst_engine.sv
logic/l2_smi_top.sv
verification/l2_smi_sva.sv
verification/l2_smi_tb.sv

/* logic/l2_line_burst_engine.sv */
// Moves whole cache lines to and from memory as 16-beat bursts on the system bus
`timescale 1ns/1ps

module l2_line_burst_engine
	(
	input logic clk,
	input logic reset_n,
	l2_smi_if.engine smi_bus,
	output l2_smi_pkg::bus_addr_t awaddr_o,
	output logic awvalid_o,
	input logic awready_i,
	output l2_smi_pkg::bus_word_t wdata_o,
	output logic wvalid_o,
	output logic wlast_o,
	input logic wready_i,
	input logic bvalid_i,
	output l2_smi_pkg::bus_addr_t araddr_o,
	output logic arvalid_o,
	input logic arready_i,
	output logic rready_o,
	input logic rvalid_i,
	input l2_smi_pkg::bus_word_t rdata_i,
	output l2_smi_pkg::line_data_t load_buffer_o,
	output logic data_ready_o
	);

	import l2_smi_pkg::*;

	smi_state_t state;
	smi_state_t state_next;
	logic [$clog2(BURST_BEATS)-1:0] beat;
	logic last_beat;
	logic write_resp_pending;
	bus_word_t load_buffer [BURST_BEATS];

	// Line aligned byte addresses
	assign awaddr_o = {smi_bus.wb_address, 6'd0};
	assign araddr_o = {smi_bus.ld_address, 6'd0};

	assign last_beat = (beat == ($clog2(BURST_BEATS))'(BURST_BEATS - 1));

	// Bus levels follow the state directly
	assign awvalid_o = (state == SMI_WRITE_ADDRESS);
	assign wvalid_o = (state == SMI_WRITE_TRANSFER);
	assign wlast_o = wvalid_o && last_beat;
	assign arvalid_o = (state == SMI_READ_ADDRESS);
	assign rready_o = (state == SMI_READ_TRANSFER);
	assign data_ready_o = (state == SMI_READ_COMPLETE);

	// Queue pops
	assign smi_bus.wb_done = wlast_o && wready_i;
	assign smi_bus.ld_done = data_ready_o;

	always_comb
	begin
		state_next = state;
		case (state)
			SMI_IDLE:
			begin
				// Writeback first, so a later load never reads a stale line
				if (smi_bus.wb_pending)
				begin
					if (!write_resp_pending)
						state_next = SMI_WRITE_ADDRESS;
				end
				else if (smi_bus.ld_pending)
				begin
					// Line already fetched by an earlier miss, just hand it back
					if (smi_bus.ld_duplicate)
						state_next = SMI_READ_COMPLETE;
					else
						state_next = SMI_READ_ADDRESS;
				end
			end

			SMI_WRITE_ADDRESS:
				if (awready_i)
					state_next = SMI_WRITE_TRANSFER;

			SMI_WRITE_TRANSFER:
				if (wready_i && last_beat)
					state_next = SMI_IDLE;

			SMI_READ_ADDRESS:
				if (arready_i)
					state_next = SMI_READ_TRANSFER;

			SMI_READ_TRANSFER:
				if (rvalid_i && last_beat)
					state_next = SMI_READ_COMPLETE;

			SMI_READ_COMPLETE:
				state_next = SMI_IDLE;

			default:
				state_next = SMI_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= SMI_IDLE;
			beat <= '0;
			write_resp_pending <= 1'b0;
		end
		else
		begin
			state <= state_next;

			// Beat counter restarts at each address phase
			if (awvalid_o || arvalid_o)
				beat <= '0;
			else if ((wvalid_o && wready_i) || (rready_o && rvalid_i))
				beat <= beat + 1'b1;

			// Only one write response outstanding at a time
			if (awvalid_o && awready_i)
				write_resp_pending <= 1'b1;
			else if (bvalid_i)
				write_resp_pending <= 1'b0;
		end
	end

	// Read beat k lands in word k
	always_ff @(posedge clk)
	begin
		if (rready_o && rvalid_i)
			load_buffer[beat] <= rdata_i;
	end

	// Word 0 in the top bits of the line
	always_comb
	begin
		for (int k = 0; k < BURST_BEATS; k++)
			load_buffer_o[(BURST_BEATS - 1 - k) * $bits(bus_word_t) +: $bits(bus_word_t)] =
				load_buffer[k];
	end

	// Write lane for the current beat
	assign wdata_o = smi_bus.wb_data[(BURST_BEATS - 1 - beat) * $bits(bus_word_t)
		+: $bits(bus_word_t)];

endmodule

/* logic/l2_miss_queues.sv */
// Sorts read-stage requests into writeback and load queues and presents their heads
`timescale 1ns/1ps

module l2_miss_queues
	(
	input logic clk,
	input logic reset_n,
	input logic rd_valid_i,
	input l2_smi_pkg::unit_t rd_unit_i,
	input l2_smi_pkg::strand_t rd_strand_i,
	input l2_smi_pkg::l2req_op_t rd_op_i,
	input l2_smi_pkg::way_t rd_way_i,
	input l2_smi_pkg::line_addr_t rd_address_i,
	input l2_smi_pkg::line_data_t rd_data_i,
	input l2_smi_pkg::byte_mask_t rd_mask_i,
	input logic rd_has_sm_data_i,
	input l2_smi_pkg::way_t rd_replace_way_i,
	input logic rd_cache_hit_i,
	input l2_smi_pkg::line_data_t rd_mem_result_i,
	input l2_smi_pkg::l2_tag_t rd_old_tag_i,
	input logic rd_line_dirty_i,
	output logic input_wait_o,
	output l2_smi_pkg::unit_t unit_o,
	output l2_smi_pkg::strand_t strand_o,
	output l2_smi_pkg::l2req_op_t op_o,
	output l2_smi_pkg::way_t way_o,
	output l2_smi_pkg::line_data_t data_o,
	output l2_smi_pkg::byte_mask_t mask_o,
	output l2_smi_pkg::way_t fill_way_o,
	l2_smi_if.queue smi_bus
	);

	import l2_smi_pkg::*;

	logic enqueue_wb;
	logic enqueue_load;
	logic duplicate;
	set_index_t set_index;
	line_addr_t wb_address;
	logic [WB_ENTRY_BITS-1:0] wb_head;
	logic [LOAD_ENTRY_BITS-1:0] load_head;
	logic [$bits(l2req_op_t)-1:0] head_op;
	logic wb_empty;
	logic load_empty;
	logic wb_almost_full;
	logic load_almost_full;

	// Dirty victim on a fill, or a flush of a dirty line
	assign enqueue_wb = rd_valid_i && rd_line_dirty_i
		&& (rd_op_i == L2REQ_FLUSH || rd_has_sm_data_i);
	// Miss that still needs its line
	assign enqueue_load = rd_valid_i && !rd_cache_hit_i && !rd_has_sm_data_i
		&& rd_op_i != L2REQ_FLUSH && rd_op_i != L2REQ_INVALIDATE;

	// Victim lives at the old tag in the same set
	assign set_index = rd_address_i[$bits(set_index_t)-1:0];
	assign wb_address = {rd_old_tag_i, set_index};

	l2_pending_miss pending_miss
	(
		.clk(clk),
		.reset_n(reset_n),
		.valid_i(rd_valid_i),
		.address_i(rd_address_i),
		.allocate_i(enqueue_load),
		.has_sm_data_i(rd_has_sm_data_i),
		.duplicate_o(duplicate)
	);

	l2_request_fifo #(.WIDTH(WB_ENTRY_BITS), .DEPTH(REQUEST_QUEUE_DEPTH)) wb_queue
	(
		.clk(clk),
		.reset_n(reset_n),
		.enqueue_i(enqueue_wb),
		.value_i({wb_address, rd_mem_result_i}),
		.dequeue_i(smi_bus.wb_done),
		.value_o(wb_head),
		.empty_o(wb_empty),
		.almost_full_o(wb_almost_full)
	);

	l2_request_fifo #(.WIDTH(LOAD_ENTRY_BITS), .DEPTH(REQUEST_QUEUE_DEPTH)) load_queue
	(
		.clk(clk),
		.reset_n(reset_n),
		.enqueue_i(enqueue_load),
		.value_i({duplicate, rd_replace_way_i, rd_unit_i, rd_strand_i, rd_op_i, rd_way_i,
			rd_address_i, rd_data_i, rd_mask_i}),
		.dequeue_i(smi_bus.ld_done),
		.value_o(load_head),
		.empty_o(load_empty),
		.almost_full_o(load_almost_full)
	);

	// Writeback head
	assign {smi_bus.wb_address, smi_bus.wb_data} = wb_head;
	assign smi_bus.wb_pending = !wb_empty;

	// Load head, same field order as the packing above
	assign {smi_bus.ld_duplicate, fill_way_o, unit_o, strand_o, head_op, way_o,
		smi_bus.ld_address, data_o, mask_o} = load_head;
	assign op_o = l2req_op_t'(head_op);
	assign smi_bus.ld_pending = !load_empty;

	// Pipeline must stop issuing while either queue is near full
	assign input_wait_o = wb_almost_full || load_almost_full;

endmodule

/* logic/l2_pending_miss.sv */
// Tracks line addresses with a fill in progress so a second miss skips the memory read
`timescale 1ns/1ps

module l2_pending_miss
	(
	input logic clk,
	input logic reset_n,
	input logic valid_i,
	input l2_smi_pkg::line_addr_t address_i,
	input logic allocate_i,
	input logic has_sm_data_i,
	output logic duplicate_o
	);

	import l2_smi_pkg::*;

	logic [PENDING_MISS_ENTRIES-1:0] entry_valid;
	line_addr_t entry_address [PENDING_MISS_ENTRIES];
	logic [PENDING_MISS_ENTRIES-1:0] entry_match;
	logic [PENDING_MISS_ENTRIES-1:0] free_select;
	logic take_entry;

	// Compare against all live entries
	always_comb
	begin
		for (int i = 0; i < PENDING_MISS_ENTRIES; i++)
			entry_match[i] = entry_valid[i] && (entry_address[i] == address_i);
	end

	assign duplicate_o = |entry_match;

	// Lowest clear valid bit, zero when the table is full
	assign free_select = ~entry_valid & (entry_valid + 1'b1);
	// A full table just lets the miss go to memory untracked
	assign take_entry = allocate_i && !duplicate_o;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			entry_valid <= '0;
		else
		begin
			for (int i = 0; i < PENDING_MISS_ENTRIES; i++)
			begin
				if (take_entry && free_select[i])
					entry_valid[i] <= 1'b1;
				// Reissued fill arrives with the line, entry retires
				else if (valid_i && has_sm_data_i && entry_match[i])
					entry_valid[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < PENDING_MISS_ENTRIES; i++)
			if (take_entry && free_select[i])
				entry_address[i] <= address_i;
	end

endmodule

/* logic/l2_request_fifo.sv */
// Circular request queue whose almost-full flag rises early enough to absorb in-flight requests
`timescale 1ns/1ps

module l2_request_fifo
	#(
	parameter int WIDTH = 32,
	parameter int DEPTH = l2_smi_pkg::REQUEST_QUEUE_DEPTH
	)
	(
	input logic clk,
	input logic reset_n,
	input logic enqueue_i,
	input logic [WIDTH-1:0] value_i,
	input logic dequeue_i,
	output logic [WIDTH-1:0] value_o,
	output logic empty_o,
	output logic almost_full_o
	);

	import l2_smi_pkg::*;

	logic [WIDTH-1:0] storage [DEPTH];
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	// Pointers, occupancy
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue_i)
				wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (dequeue_i)
				rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			// Simultaneous push and pop leaves the count alone
			case ({enqueue_i, dequeue_i})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Entry storage
	always_ff @(posedge clk)
	begin
		if (enqueue_i)
			storage[wr_ptr] <= value_i;
	end

	// Head visible one cycle after the write
	assign value_o = storage[rd_ptr];
	assign empty_o = (count == '0);

	// Leave room for requests already in the pipeline
	assign almost_full_o = (count >= ($clog2(DEPTH + 1))'(DEPTH - L2REQ_LATENCY));

endmodule

/* logic/l2_smi_if.sv */
// Queue heads toward the burst engine and its dequeue strobes back to the queues
`timescale 1ns/1ps

interface l2_smi_if;
	import l2_smi_pkg::*;

	// Writeback queue head
	logic wb_pending;
	line_addr_t wb_address;
	line_data_t wb_data;

	// Load queue head
	logic ld_pending;
	logic ld_duplicate;
	line_addr_t ld_address;

	// One cycle pulses, each pops its queue
	logic wb_done;
	logic ld_done;

	modport queue
	(
		output wb_pending,
		output wb_address,
		output wb_data,
		output ld_pending,
		output ld_duplicate,
		output ld_address,
		input wb_done,
		input ld_done
	);

	modport engine
	(
		input wb_pending,
		input wb_address,
		input wb_data,
		input ld_pending,
		input ld_duplicate,
		input ld_address,
		output wb_done,
		output ld_done
	);

endinterface

/* logic/l2_smi_pkg.sv */
// Shared widths, queue constants and enums; imported by every module of the L2 memory interface
package l2_smi_pkg;

	// Line and bus types
	typedef logic [25:0] line_addr_t;
	typedef logic [5:0] set_index_t;
	typedef logic [19:0] l2_tag_t;
	typedef logic [511:0] line_data_t;
	typedef logic [63:0] byte_mask_t;
	typedef logic [31:0] bus_word_t;
	typedef logic [31:0] bus_addr_t;

	// Request identification
	typedef logic [1:0] way_t;
	typedef logic [1:0] unit_t;
	typedef logic [1:0] strand_t;

	typedef enum logic [2:0]
	{
		L2REQ_LOAD = 3'd0,
		L2REQ_STORE = 3'd1,
		L2REQ_FLUSH = 3'd2,
		L2REQ_INVALIDATE = 3'd3
	} l2req_op_t;

	// Burst engine states
	typedef enum logic [2:0]
	{
		SMI_IDLE = 3'd0,
		SMI_WRITE_ADDRESS = 3'd1,
		SMI_WRITE_TRANSFER = 3'd2,
		SMI_READ_ADDRESS = 3'd3,
		SMI_READ_TRANSFER = 3'd4,
		SMI_READ_COMPLETE = 3'd5
	} smi_state_t;

	localparam int REQUEST_QUEUE_DEPTH = 8;
	// Pipeline stages that may still deliver requests after input wait rises
	localparam int L2REQ_LATENCY = 4;
	// 64 byte line over a 32 bit bus
	localparam int BURST_BEATS = 16;
	localparam int PENDING_MISS_ENTRIES = 4;

	// Duplicate flag, fill way, unit, strand, op, way, address, data, mask
	localparam int LOAD_ENTRY_BITS = 1 + 2 * $bits(way_t) + $bits(unit_t) + $bits(strand_t)
		+ $bits(l2req_op_t) + $bits(line_addr_t) + $bits(line_data_t) + $bits(byte_mask_t);
	// Victim address and victim line, 538 bits
	localparam int WB_ENTRY_BITS = $bits(line_addr_t) + $bits(line_data_t);

endpackage

/* logic/l2_smi_top.sv */
// L2 system memory interface top; plain ports toward the L2 pipeline and the memory bus
`timescale 1ns/1ps

module l2_smi_top
	(
	input logic clk,
	input logic reset_n,
	// Request from the read stage
	input logic rd_valid_i,
	input l2_smi_pkg::unit_t rd_unit_i,
	input l2_smi_pkg::strand_t rd_strand_i,
	input l2_smi_pkg::l2req_op_t rd_op_i,
	input l2_smi_pkg::way_t rd_way_i,
	input l2_smi_pkg::line_addr_t rd_address_i,
	input l2_smi_pkg::line_data_t rd_data_i,
	input l2_smi_pkg::byte_mask_t rd_mask_i,
	input logic rd_has_sm_data_i,
	input l2_smi_pkg::way_t rd_replace_way_i,
	input logic rd_cache_hit_i,
	input l2_smi_pkg::line_data_t rd_mem_result_i,
	input l2_smi_pkg::l2_tag_t rd_old_tag_i,
	input logic rd_line_dirty_i,
	// Fill response toward the arbiter
	output logic input_wait_o,
	output logic duplicate_o,
	output l2_smi_pkg::unit_t unit_o,
	output l2_smi_pkg::strand_t strand_o,
	output l2_smi_pkg::l2req_op_t op_o,
	output l2_smi_pkg::way_t way_o,
	output l2_smi_pkg::line_addr_t address_o,
	output l2_smi_pkg::line_data_t data_o,
	output l2_smi_pkg::byte_mask_t mask_o,
	output l2_smi_pkg::way_t fill_way_o,
	output l2_smi_pkg::line_data_t load_buffer_o,
	output logic data_ready_o,
	// Memory bus
	output l2_smi_pkg::bus_addr_t awaddr_o,
	output logic awvalid_o,
	input logic awready_i,
	output l2_smi_pkg::bus_word_t wdata_o,
	output logic wvalid_o,
	output logic wlast_o,
	input logic wready_i,
	input logic bvalid_i,
	output l2_smi_pkg::bus_addr_t araddr_o,
	output logic arvalid_o,
	input logic arready_i,
	output logic rready_o,
	input logic rvalid_i,
	input l2_smi_pkg::bus_word_t rdata_i
	);

	l2_smi_if smi_bus();

	l2_miss_queues miss_queues
	(
		.clk(clk),
		.reset_n(reset_n),
		.rd_valid_i(rd_valid_i),
		.rd_unit_i(rd_unit_i),
		.rd_strand_i(rd_strand_i),
		.rd_op_i(rd_op_i),
		.rd_way_i(rd_way_i),
		.rd_address_i(rd_address_i),
		.rd_data_i(rd_data_i),
		.rd_mask_i(rd_mask_i),
		.rd_has_sm_data_i(rd_has_sm_data_i),
		.rd_replace_way_i(rd_replace_way_i),
		.rd_cache_hit_i(rd_cache_hit_i),
		.rd_mem_result_i(rd_mem_result_i),
		.rd_old_tag_i(rd_old_tag_i),
		.rd_line_dirty_i(rd_line_dirty_i),
		.input_wait_o(input_wait_o),
		.unit_o(unit_o),
		.strand_o(strand_o),
		.op_o(op_o),
		.way_o(way_o),
		.data_o(data_o),
		.mask_o(mask_o),
		.fill_way_o(fill_way_o),
		.smi_bus(smi_bus.queue)
	);

	l2_line_burst_engine burst_engine
	(
		.clk(clk),
		.reset_n(reset_n),
		.smi_bus(smi_bus.engine),
		.awaddr_o(awaddr_o),
		.awvalid_o(awvalid_o),
		.awready_i(awready_i),
		.wdata_o(wdata_o),
		.wvalid_o(wvalid_o),
		.wlast_o(wlast_o),
		.wready_i(wready_i),
		.bvalid_i(bvalid_i),
		.araddr_o(araddr_o),
		.arvalid_o(arvalid_o),
		.arready_i(arready_i),
		.rready_o(rready_o),
		.rvalid_i(rvalid_i),
		.rdata_i(rdata_i),
		.load_buffer_o(load_buffer_o),
		.data_ready_o(data_ready_o)
	);

	// Address and duplicate flag of the load head are shared with the engine
	assign address_o = smi_bus.ld_address;
	assign duplicate_o = smi_bus.ld_duplicate;

endmodule

/* verification/l2_smi_sva.sv */
// Bus protocol properties of the burst engine; bound into every engine instance at elaboration
`timescale 1ns/1ps

module l2_smi_sva
	(
	input logic clk,
	input logic reset_n,
	input logic awvalid_i,
	input logic awready_i,
	input logic wvalid_i,
	input logic wlast_i,
	input logic arvalid_i,
	input logic arready_i,
	input logic data_ready_i
	);

	// Read back by the testbench summary
	int failure_count = 0;

	// Write address held until accepted
	aw_held: assert property (@(posedge clk) disable iff (!reset_n)
		awvalid_i && !awready_i |=> awvalid_i)
	else
	begin
		failure_count++;
		$error("awvalid dropped before awready");
	end

	// Read address held until accepted
	ar_held: assert property (@(posedge clk) disable iff (!reset_n)
		arvalid_i && !arready_i |=> arvalid_i)
	else
	begin
		failure_count++;
		$error("arvalid dropped before arready");
	end

	// Last beat flag only on a valid beat
	wlast_with_valid: assert property (@(posedge clk) disable iff (!reset_n)
		wlast_i |-> wvalid_i)
	else
	begin
		failure_count++;
		$error("wlast without wvalid");
	end

	// Fill strobe is a single pulse
	data_ready_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		data_ready_i |=> !data_ready_i)
	else
	begin
		failure_count++;
		$error("data_ready longer than one cycle");
	end

	// One address channel active at a time
	one_address_channel: assert property (@(posedge clk) disable iff (!reset_n)
		!(awvalid_i && arvalid_i))
	else
	begin
		failure_count++;
		$error("awvalid and arvalid high together");
	end

endmodule

bind l2_line_burst_engine l2_smi_sva protocol_checks
(
	.clk(clk),
	.reset_n(reset_n),
	.awvalid_i(awvalid_o),
	.awready_i(awready_i),
	.wvalid_i(wvalid_o),
	.wlast_i(wlast_o),
	.arvalid_i(arvalid_o),
	.arready_i(arready_i),
	.data_ready_i(data_ready_o)
);

/* verification/l2_smi_tb.sv */
// Testbench for the L2 memory interface; issues read-stage requests, models memory, checks fills
`timescale 1ns/1ps

module l2_smi_tb;
	import l2_smi_pkg::*;

	localparam int WAIT_LIMIT = 20000;
	localparam int SETTLE_CYCLES = 20;

	// Expected fill response that also serves as an expected read burst
	typedef struct
	{
		int seq;
		logic duplicate;
		way_t fill_way;
		unit_t unit;
		strand_t strand;
		l2req_op_t op;
		way_t way;
		line_addr_t address;
		line_data_t data;
		byte_mask_t mask;
	} load_expect_t;

	// Expected write burst
	typedef struct
	{
		int seq;
		line_addr_t address;
		line_data_t line;
	} wb_expect_t;

	logic clk;
	logic reset_n;
	logic rd_valid_i;
	unit_t rd_unit_i;
	strand_t rd_strand_i;
	l2req_op_t rd_op_i;
	way_t rd_way_i;
	line_addr_t rd_address_i;
	line_data_t rd_data_i;
	byte_mask_t rd_mask_i;
	logic rd_has_sm_data_i;
	way_t rd_replace_way_i;
	logic rd_cache_hit_i;
	line_data_t rd_mem_result_i;
	l2_tag_t rd_old_tag_i;
	logic rd_line_dirty_i;
	logic input_wait_o;
	logic duplicate_o;
	unit_t unit_o;
	strand_t strand_o;
	l2req_op_t op_o;
	way_t way_o;
	line_addr_t address_o;
	line_data_t data_o;
	byte_mask_t mask_o;
	way_t fill_way_o;
	line_data_t load_buffer_o;
	logic data_ready_o;
	bus_addr_t awaddr_o;
	logic awvalid_o;
	logic awready_i;
	bus_word_t wdata_o;
	logic wvalid_o;
	logic wlast_o;
	logic wready_i;
	logic bvalid_i;
	bus_addr_t araddr_o;
	logic arvalid_o;
	logic arready_i;
	logic rready_o;
	logic rvalid_i;
	bus_word_t rdata_i;

	// Scoreboard queues and pending-line model
	load_expect_t load_q[$];
	load_expect_t read_q[$];
	wb_expect_t wb_q[$];
	line_addr_t pending_lines[$];
	load_expect_t fill_head;

	// Memory model state
	bus_word_t mem_array [bus_addr_t];
	int seed = 32'h7bbde82f;
	int stall_odds = 0;
	line_addr_t write_line;
	int write_beat = 0;
	logic write_active = 1'b0;
	line_data_t written_line;
	int bresp_wait = 0;
	logic bresp_due = 1'b0;
	line_addr_t read_line;
	int read_beat = 0;
	logic read_active = 1'b0;
	logic r_taken = 1'b0;

	// Counters
	int aw_count = 0;
	int ar_count = 0;
	int seq_count = 0;
	int loads_queued = 0;
	int responses = 0;
	int checks_run = 0;
	int value_errors = 0;
	int other_errors = 0;
	string test_name = "reset";

	l2_smi_top l2_smi_top_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Reference memory; untouched words are a hash of the byte address
	function automatic bus_word_t mem_word(input line_addr_t line, input int beat);
		bus_addr_t byte_address;
		byte_address = {line, 6'd0} + bus_addr_t'(beat * 4);
		if (mem_array.exists(byte_address))
			return mem_array[byte_address];
		return (byte_address * 32'h9e3779b1) ^ {byte_address[15:0], byte_address[31:16]}
			^ 32'h3c5a96e1;
	endfunction

	// Expected line with word 0 in the top bits
	function automatic line_data_t expected_line(input line_addr_t line);
		line_data_t result;
		for (int k = 0; k < BURST_BEATS; k++)
			result[(BURST_BEATS - 1 - k) * 32 +: 32] = mem_word(line, k);
		return result;
	endfunction

	// Ready or valid draw that stalls stall_odds out of 16 cycles
	function automatic logic bus_go();
		int draw;
		draw = $random(seed);
		return (draw & 15) >= stall_odds;
	endfunction

	function automatic line_data_t random_line();
		line_data_t result;
		for (int k = 0; k < BURST_BEATS; k++)
			result[k * 32 +: 32] = $random(seed);
		return result;
	endfunction

	task automatic check_value(input string label, input logic [511:0] expected,
		input logic [511:0] actual);
		checks_run++;
		if (expected !== actual)
		begin
			value_errors++;
			$display("Error %s %s: expected %0h, actual %0h", test_name, label, expected, actual);
		end
	endtask

	task automatic note_failure(input string what);
		other_errors++;
		$display("%s during %s", what, test_name);
	endtask

	task automatic abort_run(input string why);
		$display("%s during %s", why, test_name);
		$display("Something failed");
		$finish;
	endtask

	// Pipeline stalls while input wait is high
	task automatic wait_for_room();
		int cycles;
		cycles = 0;
		while (input_wait_o && cycles < WAIT_LIMIT)
		begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (input_wait_o)
			abort_run("Timed out waiting for input wait to drop");
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while ((load_q.size() != 0 || wb_q.size() != 0 || bresp_due) && cycles < WAIT_LIMIT)
		begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (load_q.size() != 0 || wb_q.size() != 0 || bresp_due)
			abort_run("Timed out waiting for outstanding requests to finish");
	endtask

	// Drives one request and records what the classification rules expect from it
	task automatic issue_request(input l2req_op_t op, input line_addr_t address,
		input logic hit, input logic has_sm_data, input logic dirty, input l2_tag_t old_tag,
		input line_data_t victim);
		load_expect_t load_entry;
		wb_expect_t wb_entry;
		logic found;
		wait_for_room();
		rd_valid_i = 1'b1;
		rd_op_i = op;
		rd_address_i = address;
		rd_cache_hit_i = hit;
		rd_has_sm_data_i = has_sm_data;
		rd_line_dirty_i = dirty;
		rd_old_tag_i = old_tag;
		rd_mem_result_i = victim;
		rd_unit_i = unit_t'($random(seed));
		rd_strand_i = strand_t'($random(seed));
		rd_way_i = way_t'($random(seed));
		rd_replace_way_i = way_t'($random(seed));
		rd_data_i = random_line();
		rd_mask_i = {$random(seed), $random(seed)};
		seq_count++;

		// Dirty victim on a fill, or dirty flush
		if (dirty && (op == L2REQ_FLUSH || has_sm_data))
		begin
			wb_entry.seq = seq_count;
			wb_entry.address = {old_tag, address[5:0]};
			wb_entry.line = victim;
			wb_q.push_back(wb_entry);
		end

		found = 1'b0;
		foreach (pending_lines[i])
			if (pending_lines[i] == address)
				found = 1'b1;
		// Reissued fill retires its pending line
		if (has_sm_data)
			for (int i = pending_lines.size() - 1; i >= 0; i--)
				if (pending_lines[i] == address)
					pending_lines.delete(i);

		if (!hit && !has_sm_data && op != L2REQ_FLUSH && op != L2REQ_INVALIDATE)
		begin
			load_entry.seq = seq_count;
			load_entry.duplicate = found;
			load_entry.fill_way = rd_replace_way_i;
			load_entry.unit = rd_unit_i;
			load_entry.strand = rd_strand_i;
			load_entry.op = op;
			load_entry.way = rd_way_i;
			load_entry.address = address;
			load_entry.data = rd_data_i;
			load_entry.mask = rd_mask_i;
			load_q.push_back(load_entry);
			loads_queued++;
			// Only a new line goes to memory; a full table leaves it untracked
			if (!found)
			begin
				read_q.push_back(load_entry);
				if (pending_lines.size() < PENDING_MISS_ENTRIES)
					pending_lines.push_back(address);
			end
		end
		@(posedge clk);
		#2;
		rd_valid_i = 1'b0;
	endtask

	// Memory model sampling handshakes at the falling edge and driving after the rising edge
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (reset_n)
			begin
				if (awvalid_o && awready_i)
				begin
					aw_count++;
					if (wb_q.size() == 0)
						note_failure("Write burst started with no writeback queued");
					else
						check_value("writeback address", {wb_q[0].address, 6'd0}, awaddr_o);
					write_line = awaddr_o[31:6];
					write_beat = 0;
					write_active = 1'b1;
				end
				if (wvalid_o && wready_i)
				begin
					if (!write_active)
						note_failure("Write beat with no write burst in progress");
					check_value("wlast", write_beat == BURST_BEATS - 1, wlast_o);
					mem_array[{write_line, 6'd0} + bus_addr_t'(write_beat * 4)] = wdata_o;
					written_line[(BURST_BEATS - 1 - write_beat) * 32 +: 32] = wdata_o;
					write_beat++;
					if (write_beat == BURST_BEATS)
					begin
						if (wb_q.size() != 0)
						begin
							check_value("writeback line", wb_q[0].line, written_line);
							wb_q.delete(0);
						end
						write_active = 1'b0;
						bresp_due = 1'b1;
						bresp_wait = $random(seed) & 3;
					end
				end
				if (arvalid_o && arready_i)
				begin
					ar_count++;
					if (read_q.size() == 0)
						note_failure("Read burst started with no fill outstanding");
					else
					begin
						check_value("read address", {read_q[0].address, 6'd0}, araddr_o);
						// Older writebacks must already be on the bus
						if (wb_q.size() != 0 && wb_q[0].seq < read_q[0].seq)
							note_failure("Read address issued ahead of an older writeback");
						read_q.delete(0);
					end
					read_line = araddr_o[31:6];
					read_beat = 0;
					read_active = 1'b1;
				end
				r_taken = rvalid_i && rready_o;
				if (r_taken)
				begin
					read_beat++;
					if (read_beat == BURST_BEATS)
						read_active = 1'b0;
				end
			end
			@(posedge clk);
			#2;
			awready_i = bus_go();
			wready_i = bus_go();
			arready_i = bus_go();
			if (bresp_due && bresp_wait == 0)
			begin
				bvalid_i = 1'b1;
				bresp_due = 1'b0;
			end
			else
			begin
				bvalid_i = 1'b0;
				if (bresp_due)
					bresp_wait--;
			end
			// A beat not yet taken stays on the bus
			if (!read_active)
				rvalid_i = 1'b0;
			else if (!(rvalid_i && !r_taken))
			begin
				rvalid_i = bus_go();
				rdata_i = mem_word(read_line, read_beat);
			end
		end
	end

	// Fill response checker
	always @(negedge clk)
	begin
		if (reset_n && data_ready_o)
		begin
			responses++;
			if (load_q.size() == 0)
				note_failure("Fill response with no load outstanding");
			else
			begin
				fill_head = load_q.pop_front();
				check_value("duplicate", fill_head.duplicate, duplicate_o);
				check_value("unit", fill_head.unit, unit_o);
				check_value("strand", fill_head.strand, strand_o);
				check_value("op", fill_head.op, op_o);
				check_value("way", fill_head.way, way_o);
				check_value("address", fill_head.address, address_o);
				check_value("data", fill_head.data, data_o);
				check_value("mask", fill_head.mask, mask_o);
				check_value("fill way", fill_head.fill_way, fill_way_o);
				// A duplicate carries no new line of its own
				if (!fill_head.duplicate)
					check_value("load buffer", expected_line(fill_head.address), load_buffer_o);
			end
		end
	end

	initial
	begin
		int reads_before;
		int writes_before;
		int responses_before;
		int loads_before;
		int draw;
		int sva_failures;
		reset_n = 1'b0;
		rd_valid_i = 1'b0;
		rd_unit_i = '0;
		rd_strand_i = '0;
		rd_op_i = L2REQ_LOAD;
		rd_way_i = '0;
		rd_address_i = '0;
		rd_data_i = '0;
		rd_mask_i = '0;
		rd_has_sm_data_i = 1'b0;
		rd_replace_way_i = '0;
		rd_cache_hit_i = 1'b0;
		rd_mem_result_i = '0;
		rd_old_tag_i = '0;
		rd_line_dirty_i = 1'b0;
		awready_i = 1'b0;
		wready_i = 1'b0;
		bvalid_i = 1'b0;
		arready_i = 1'b0;
		rvalid_i = 1'b0;
		rdata_i = '0;
		repeat (4) @(posedge clk);
		#2;
		reset_n = 1'b1;
		check_value("idle outputs", 7'd0, {awvalid_o, wvalid_o, wlast_o, arvalid_o, rready_o,
			data_ready_o, input_wait_o});

		test_name = "clean miss";
		stall_odds = 4;
		issue_request(L2REQ_LOAD, 26'h0123456, 1'b0, 1'b0, 1'b0, '0, '0);
		issue_request(L2REQ_STORE, 26'h0123457, 1'b0, 1'b0, 1'b0, '0, '0);
		wait_drained();

		// Victim written back, then its line is missed on right away
		test_name = "dirty victim";
		issue_request(L2REQ_LOAD, 26'h0345678, 1'b0, 1'b1, 1'b1, 20'h9abcd, random_line());
		issue_request(L2REQ_LOAD, {20'h9abcd, 6'h38}, 1'b0, 1'b0, 1'b0, '0, '0);
		wait_drained();

		test_name = "duplicate miss";
		reads_before = ar_count;
		issue_request(L2REQ_LOAD, 26'h0456789, 1'b0, 1'b0, 1'b0, '0, '0);
		issue_request(L2REQ_STORE, 26'h0456789, 1'b0, 1'b0, 1'b0, '0, '0);
		wait_drained();
		check_value("read bursts", 1, ar_count - reads_before);
		// Reissue frees the line so the next miss reads again
		issue_request(L2REQ_LOAD, 26'h0456789, 1'b0, 1'b1, 1'b0, '0, '0);
		issue_request(L2REQ_LOAD, 26'h0456789, 1'b0, 1'b0, 1'b0, '0, '0);
		wait_drained();
		check_value("read bursts after reissue", 2, ar_count - reads_before);

		test_name = "flush and no traffic";
		reads_before = ar_count;
		writes_before = aw_count;
		responses_before = responses;
		issue_request(L2REQ_FLUSH, 26'h0567890, 1'b1, 1'b0, 1'b1, 20'h13579, random_line());
		wait_drained();
		check_value("flush write bursts", 1, aw_count - writes_before);
		issue_request(L2REQ_LOAD, 26'h0567891, 1'b1, 1'b0, 1'b0, '0, '0);
		issue_request(L2REQ_FLUSH, 26'h0567892, 1'b1, 1'b0, 1'b0, '0, '0);
		issue_request(L2REQ_INVALIDATE, 26'h0567893, 1'b0, 1'b0, 1'b1, 20'h2468a, '0);
		repeat (SETTLE_CYCLES) @(posedge clk);
		#2;
		check_value("write bursts", 1, aw_count - writes_before);
		check_value("read bursts", 0, ar_count - reads_before);
		check_value("responses", 0, responses - responses_before);

		// Long stalls so the queues fill up to input wait
		test_name = "back-pressure";
		stall_odds = 12;
		responses_before = responses;
		loads_before = loads_queued;
		for (int n = 0; n < 80; n++)
		begin
			draw = $random(seed);
			issue_request(l2req_op_t'(draw & 3), 26'h0200000 + line_addr_t'((draw >> 2) & 7),
				((draw >> 5) & 7) == 0, ((draw >> 8) & 3) == 0, draw[10],
				l2_tag_t'($random(seed)), random_line());
		end
		wait_drained();
		check_value("responses", loads_queued - loads_before, responses - responses_before);

		sva_failures = l2_smi_top_inst.burst_engine.protocol_checks.failure_count;
		$display("Checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
			checks_run, value_errors, other_errors, sva_failures);
		if (value_errors == 0 && other_errors == 0 && sva_failures == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
